/* snes_rom_pkg.sv */
package snes_rom_pkg;

  //////////////////////////////////////////////////////////////////////////
  // Bus widths
  //////////////////////////////////////////////////////////////////////////
  localparam int snes_addr_w = 24;
  localparam int rom_addr_w  = 23;  // PSRAM word address
  localparam int byte_w      = 8;
  localparam int rom_word_w  = 16;

  // Pin synchronizer depths
  localparam int sync_depth      = 8;
  localparam int addr_sync_depth = 6;
  localparam int data_sync_depth = 5;

  //////////////////////////////////////////////////////////////////////////
  // Timing
  //////////////////////////////////////////////////////////////////////////
  localparam logic [3:0] rom_cycle_len = 4'd7;  // Extra cycles per MCU access

  localparam int dead_cnt_w = 18;
  localparam logic [dead_cnt_w-1:0] snes_dead_timeout = 18'd86000;  // About 1 ms

  // Save RAM lives at the top of PSRAM
  localparam logic [snes_addr_w-1:0] saveram_base = 24'hE00000;

  // One-hot arbiter states
  typedef enum logic [4:0] {
    st_idle        = 5'b00001,
    st_mcu_rd_addr = 5'b00010,
    st_mcu_rd_end  = 5'b00100,
    st_mcu_wr_addr = 5'b01000,
    st_mcu_wr_end  = 5'b10000
  } arb_state_t;

  // SNES address word, seen as HiROM or LoROM
  typedef union packed {
    struct packed {
      logic [7:0]  bank;
      logic [15:0] offset;
    } hi;
    struct packed {
      logic [7:0]  bank;
      logic        a15;
      logic [14:0] page;  // Offset within 32K page
    } lo;
  } snes_addr_u;

endpackage

/* snes_bus_if.sv */
`timescale 1ns/1ns

interface snes_bus_if import snes_rom_pkg::*; ();

  snes_addr_u        addr;     // Filtered address
  logic [byte_w-1:0] data_in;  // Filtered data from the SNES

  // Filtered levels, active low strobes
  logic rd;
  logic wr;
  logic cpu_clk;

  // Single-cycle events
  logic rd_start;
  logic rd_end;
  logic wr_end;
  logic cycle_start;
  logic cycle_end;

  logic dead;  // Console stopped

  modport src (
    output addr, data_in, rd, wr, cpu_clk,
    output rd_start, rd_end, wr_end, cycle_start, cycle_end, dead
  );

  modport dst (
    input addr, data_in, rd, wr, cpu_clk,
    input rd_start, rd_end, wr_end, cycle_start, cycle_end, dead
  );

endinterface

/* addr_map_if.sv */
`timescale 1ns/1ns

interface addr_map_if import snes_rom_pkg::*; ();

  logic [snes_addr_w-1:0] mapped_addr;  // PSRAM byte address
  logic                   rom_hit;      // Any region hit
  logic                   is_rom;
  logic                   is_saveram;

  modport src (
    output mapped_addr, rom_hit, is_rom, is_saveram
  );

  modport dst (
    input mapped_addr, rom_hit, is_rom, is_saveram
  );

endinterface

/* snes_bus_sync.sv */
`timescale 1ns/1ns

module snes_bus_sync import snes_rom_pkg::*; (
  input  logic                   CLK2,
  input  logic                   rst_n,
  input  logic [snes_addr_w-1:0] snes_addr_in,
  input  logic [byte_w-1:0]      snes_data_in,
  input  logic                   snes_rd_n,
  input  logic                   snes_wr_n,
  input  logic                   snes_cpu_clk,
  snes_bus_if.src                bus
);

  logic [sync_depth-1:0]  rd_sr;
  logic [sync_depth-1:0]  wr_sr;
  logic [sync_depth-1:0]  clk_sr;
  logic [snes_addr_w-1:0] addr_sr [addr_sync_depth];
  logic [byte_w-1:0]      data_sr [data_sync_depth];
  logic [dead_cnt_w-1:0]  dead_cnt;
  logic                   dead_r;
  logic                   cpu_clk_lvl;

  ////////////////////////////////////////////////////////////////////////////
  // Control pin shift registers
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      rd_sr  <= '1;  // Strobes idle high
      wr_sr  <= '1;
      clk_sr <= '0;
    end else begin
      rd_sr  <= {rd_sr[sync_depth-2:0], snes_rd_n};
      wr_sr  <= {wr_sr[sync_depth-2:0], snes_wr_n};
      clk_sr <= {clk_sr[sync_depth-2:0], snes_cpu_clk};
    end
  end

  // Address and data just ride along, no reset needed
  always_ff @(posedge CLK2) begin
    addr_sr[0] <= snes_addr_in;
    for (int i = 1; i < addr_sync_depth; i++) begin
      addr_sr[i] <= addr_sr[i-1];
    end
    data_sr[0] <= snes_data_in;
    for (int i = 1; i < data_sync_depth; i++) begin
      data_sr[i] <= data_sr[i-1];
    end
  end

  // Two agreeing samples filter single-cycle glitches
  assign bus.addr    = addr_sr[addr_sync_depth-1] & addr_sr[addr_sync_depth-2];
  assign bus.data_in = data_sr[data_sync_depth-1] & data_sr[data_sync_depth-2];
  assign bus.rd      = rd_sr[2] & rd_sr[1];
  assign bus.wr      = wr_sr[2] & wr_sr[1];
  assign cpu_clk_lvl = clk_sr[2] & clk_sr[1];
  assign bus.cpu_clk = cpu_clk_lvl;

  // Edge patterns, each matches at one shift position only
  assign bus.rd_start    = ((rd_sr[6:1] | rd_sr[7:2]) == 6'b111110);
  assign bus.rd_end      = ((rd_sr[6:1] & rd_sr[7:2]) == 6'b000001);
  assign bus.wr_end      = ((wr_sr[6:1] & wr_sr[7:2]) == 6'b000001);
  assign bus.cycle_start = ((clk_sr[5:2] & clk_sr[4:1]) == 4'b0001);
  assign bus.cycle_end   = ((clk_sr[5:2] | clk_sr[4:1]) == 4'b1110);

  ////////////////////////////////////////////////////////////////////////////
  // Dead console detection
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      dead_cnt <= '0;
      dead_r   <= 1'b1;  // Assume stopped until the clock runs
    end else begin
      if (cpu_clk_lvl) begin
        dead_cnt <= '0;
        dead_r   <= 1'b0;
      end else begin
        if (!(&dead_cnt)) dead_cnt <= dead_cnt + 1'b1;  // Saturate
        if (dead_cnt > snes_dead_timeout) dead_r <= 1'b1;
      end
    end
  end

  assign bus.dead = dead_r;

endmodule

/* snes_addr_map.sv */
`timescale 1ns/1ns

module snes_addr_map import snes_rom_pkg::*; (
  input  logic                   mapper_hirom,
  input  logic [snes_addr_w-1:0] rom_mask,
  input  logic [snes_addr_w-1:0] saveram_mask,
  snes_bus_if.dst                bus,
  addr_map_if.src                map
);

  snes_addr_u             a;
  logic                   hi_sav_sel;
  logic                   hi_rom_sel;
  logic                   lo_sav_sel;
  logic                   lo_rom_sel;
  logic                   sav_sel;
  logic                   rom_sel;
  logic [snes_addr_w-1:0] hi_sav_addr;
  logic [snes_addr_w-1:0] hi_rom_addr;
  logic [snes_addr_w-1:0] lo_sav_addr;
  logic [snes_addr_w-1:0] lo_rom_addr;

  assign a = bus.addr;

  ////////////////////////////////////////////////////////////////////////////
  // HiROM
  ////////////////////////////////////////////////////////////////////////////
  // Save RAM in banks 20-3F / A0-BF, 6000-7FFF
  assign hi_sav_sel = (a.hi.bank[6:5] == 2'b01) && (a.hi.offset[15:13] == 3'b011);
  assign hi_rom_sel = a.hi.bank[6] | a.lo.a15;

  assign hi_sav_addr = saveram_base
                     + ({6'd0, a.hi.bank[4:0], a.hi.offset[12:0]} & saveram_mask);
  assign hi_rom_addr = {2'd0, a.hi.bank[5:0], a.hi.offset} & rom_mask;

  ////////////////////////////////////////////////////////////////////////////
  // LoROM
  ////////////////////////////////////////////////////////////////////////////
  // Save RAM in banks 70-7F / F0-FF, lower half
  assign lo_sav_sel = (&a.lo.bank[6:4]) & ~a.lo.a15;
  assign lo_rom_sel = a.lo.a15;  // Upper 32K of each bank

  assign lo_sav_addr = saveram_base
                     + ({5'd0, a.lo.bank[3:0], a.lo.page} & saveram_mask);
  assign lo_rom_addr = {2'd0, a.lo.bank[6:0], a.lo.page} & rom_mask;

  // Save RAM wins over ROM
  assign sav_sel = mapper_hirom ? hi_sav_sel : lo_sav_sel;
  assign rom_sel = (mapper_hirom ? hi_rom_sel : lo_rom_sel) & ~sav_sel;

  always_comb begin
    if (sav_sel) begin
      map.mapped_addr = mapper_hirom ? hi_sav_addr : lo_sav_addr;
    end else begin
      map.mapped_addr = mapper_hirom ? hi_rom_addr : lo_rom_addr;
    end
  end

  assign map.is_saveram = sav_sel;
  assign map.is_rom     = rom_sel;
  assign map.rom_hit    = rom_sel | sav_sel;

endmodule

/* mcu_rom_arbiter.sv */
`timescale 1ns/1ns

module mcu_rom_arbiter import snes_rom_pkg::*; (
  input  logic                   CLK2,
  input  logic                   rst_n,
  input  logic                   mcu_rrq,
  input  logic                   mcu_wrq,
  input  logic [snes_addr_w-1:0] mcu_addr,
  input  logic [byte_w-1:0]      rom_rd_byte,
  output logic                   mcu_rdy,
  output logic [byte_w-1:0]      mcu_din,
  output logic                   mcu_rd_hit,
  output logic                   mcu_wr_hit,
  output logic [snes_addr_w-1:0] mcu_rom_addr,
  snes_bus_if.dst                bus,
  addr_map_if.dst                map
);

  arb_state_t                       state;
  logic [$bits(rom_cycle_len)-1:0]  delay_cnt;
  logic                             rd_pend;
  logic                             wr_pend;
  logic                             free_strobe;
  logic                             free_slot;
  logic                             access_end;

  assign access_end = (state == st_mcu_rd_end) || (state == st_mcu_wr_end);

  ////////////////////////////////////////////////////////////////////////////
  // Request latch
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      mcu_rdy <= 1'b1;
    end else if (mcu_rrq) begin
      rd_pend <= 1'b1;
      mcu_rdy <= 1'b0;
    end else if (mcu_wrq) begin
      wr_pend <= 1'b1;
      mcu_rdy <= 1'b0;
    end else if (access_end) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      mcu_rdy <= 1'b1;
    end
  end

  always_ff @(posedge CLK2) begin
    if (mcu_rrq || mcu_wrq) mcu_rom_addr <= mcu_addr;
    if (state == st_mcu_rd_addr) mcu_din <= rom_rd_byte;  // Last sample wins
  end

  // SNES cycle that misses the cartridge leaves the bus free
  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) free_strobe <= 1'b0;
    else        free_strobe <= bus.cycle_start & ~map.rom_hit;
  end

  assign free_slot = bus.cycle_end | free_strobe;

  ////////////////////////////////////////////////////////////////////////////
  // ROM access FSM
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      state     <= st_idle;
      delay_cnt <= '0;
    end else if (bus.dead && bus.cpu_clk) begin
      state <= st_idle;  // Console woke up, retry later
    end else begin
      case (state)
        st_idle: begin
          if (free_slot || bus.dead) begin
            if (rd_pend) begin
              state     <= st_mcu_rd_addr;
              delay_cnt <= rom_cycle_len;
            end else if (wr_pend) begin
              state     <= st_mcu_wr_addr;
              delay_cnt <= rom_cycle_len;
            end
          end
        end
        st_mcu_rd_addr, st_mcu_wr_addr: begin
          delay_cnt <= delay_cnt - 1'b1;
          if (delay_cnt == '0) begin
            state <= (state == st_mcu_rd_addr) ? st_mcu_rd_end : st_mcu_wr_end;
          end
        end
        default: state <= st_idle;  // End states
      endcase
    end
  end

  assign mcu_rd_hit = (state == st_mcu_rd_addr);
  assign mcu_wr_hit = (state == st_mcu_wr_addr);

endmodule

/* rom_bus_drive.sv */
`timescale 1ns/1ns

module rom_bus_drive import snes_rom_pkg::*; (
  input  logic [rom_word_w-1:0]  rom_data_in,
  input  logic [byte_w-1:0]      mcu_dout,
  input  logic                   mcu_rd_hit,
  input  logic                   mcu_wr_hit,
  input  logic [snes_addr_w-1:0] mcu_rom_addr,
  input  logic                   snes_cs_n,
  output logic [rom_addr_w-1:0]  rom_addr,
  output logic [rom_word_w-1:0]  rom_data_out,
  output logic                   rom_data_oe,
  output logic                   rom_we,
  output logic                   rom_bhe,
  output logic                   rom_ble,
  output logic [byte_w-1:0]      rom_rd_byte,
  output logic [byte_w-1:0]      snes_data_out,
  output logic                   snes_data_oe,
  output logic                   snes_databus_oe,
  output logic                   snes_databus_dir,
  snes_bus_if.dst                bus,
  addr_map_if.dst                map
);

  logic [snes_addr_w-1:0] byte_addr;
  logic                   lane_lo;     // Odd byte on D7:0
  logic                   snes_wr_act;
  logic                   sav_wr;
  logic [byte_w-1:0]      wr_byte;

  // MCU owns the address during its access window
  assign byte_addr = (mcu_rd_hit | mcu_wr_hit) ? mcu_rom_addr : map.mapped_addr;
  assign rom_addr  = byte_addr[snes_addr_w-1:1];
  assign lane_lo   = byte_addr[0];

  // Byte enables are active low
  assign rom_bhe = lane_lo;
  assign rom_ble = ~lane_lo;

  assign rom_rd_byte = lane_lo ? rom_data_in[7:0] : rom_data_in[15:8];

  ////////////////////////////////////////////////////////////////////////////
  // PSRAM write path
  ////////////////////////////////////////////////////////////////////////////
  assign snes_wr_act = map.rom_hit & ~bus.wr;
  assign wr_byte     = snes_wr_act ? bus.data_in : mcu_dout;

  assign rom_data_out = lane_lo ? {8'h00, wr_byte} : {wr_byte, 8'h00};
  assign rom_data_oe  = snes_wr_act | mcu_wr_hit;

  assign sav_wr = map.is_saveram & bus.cpu_clk & ~bus.wr;  // Only save RAM is writable
  assign rom_we = ~(mcu_wr_hit | sav_wr);

  ////////////////////////////////////////////////////////////////////////////
  // SNES data bus
  ////////////////////////////////////////////////////////////////////////////
  assign snes_data_out    = rom_rd_byte;
  assign snes_data_oe     = ~bus.rd;
  assign snes_databus_dir = ~bus.rd;  // 1 drives towards the console

  // Transceiver off for foreign ROM chips, unmapped space and idle bus
  assign snes_databus_oe = (map.is_rom & snes_cs_n)
                         | ~map.rom_hit
                         | (bus.rd & bus.wr);

endmodule

/* snes_rom_ctrl.sv */
`timescale 1ns/1ns

module snes_rom_ctrl import snes_rom_pkg::*; (
  input  logic                   CLK2,
  input  logic                   rst_n,
  // SNES side
  input  logic [snes_addr_w-1:0] snes_addr_in,
  input  logic [byte_w-1:0]      snes_data_in,
  input  logic                   snes_rd_n,
  input  logic                   snes_wr_n,
  input  logic                   snes_cpu_clk,
  input  logic                   snes_cs_n,
  output logic [byte_w-1:0]      snes_data_out,
  output logic                   snes_data_oe,
  output logic                   snes_databus_oe,
  output logic                   snes_databus_dir,
  // PSRAM
  output logic [rom_addr_w-1:0]  rom_addr,
  input  logic [rom_word_w-1:0]  rom_data_in,
  output logic [rom_word_w-1:0]  rom_data_out,
  output logic                   rom_data_oe,
  output logic                   rom_we,
  output logic                   rom_bhe,
  output logic                   rom_ble,
  // MCU
  input  logic                   mcu_rrq,
  input  logic                   mcu_wrq,
  input  logic [snes_addr_w-1:0] mcu_addr,
  input  logic [byte_w-1:0]      mcu_dout,
  output logic                   mcu_rdy,
  output logic [byte_w-1:0]      mcu_din,
  // Mapper config
  input  logic                   mapper_hirom,
  input  logic [snes_addr_w-1:0] rom_mask,
  input  logic [snes_addr_w-1:0] saveram_mask
);

  logic                   mcu_rd_hit;
  logic                   mcu_wr_hit;
  logic [snes_addr_w-1:0] mcu_rom_addr;
  logic [byte_w-1:0]      rom_rd_byte;

  snes_bus_if bus ();
  addr_map_if map ();

  snes_bus_sync u_bus_sync (
    .CLK2         (CLK2),
    .rst_n        (rst_n),
    .snes_addr_in (snes_addr_in),
    .snes_data_in (snes_data_in),
    .snes_rd_n    (snes_rd_n),
    .snes_wr_n    (snes_wr_n),
    .snes_cpu_clk (snes_cpu_clk),
    .bus          (bus.src)
  );

  snes_addr_map u_addr_map (
    .mapper_hirom (mapper_hirom),
    .rom_mask     (rom_mask),
    .saveram_mask (saveram_mask),
    .bus          (bus.dst),
    .map          (map.src)
  );

  mcu_rom_arbiter u_arbiter (
    .CLK2         (CLK2),
    .rst_n        (rst_n),
    .mcu_rrq      (mcu_rrq),
    .mcu_wrq      (mcu_wrq),
    .mcu_addr     (mcu_addr),
    .rom_rd_byte  (rom_rd_byte),
    .mcu_rdy      (mcu_rdy),
    .mcu_din      (mcu_din),
    .mcu_rd_hit   (mcu_rd_hit),
    .mcu_wr_hit   (mcu_wr_hit),
    .mcu_rom_addr (mcu_rom_addr),
    .bus          (bus.dst),
    .map          (map.dst)
  );

  rom_bus_drive u_drive (
    .rom_data_in      (rom_data_in),
    .mcu_dout         (mcu_dout),
    .mcu_rd_hit       (mcu_rd_hit),
    .mcu_wr_hit       (mcu_wr_hit),
    .mcu_rom_addr     (mcu_rom_addr),
    .snes_cs_n        (snes_cs_n),
    .rom_addr         (rom_addr),
    .rom_data_out     (rom_data_out),
    .rom_data_oe      (rom_data_oe),
    .rom_we           (rom_we),
    .rom_bhe          (rom_bhe),
    .rom_ble          (rom_ble),
    .rom_rd_byte      (rom_rd_byte),
    .snes_data_out    (snes_data_out),
    .snes_data_oe     (snes_data_oe),
    .snes_databus_oe  (snes_databus_oe),
    .snes_databus_dir (snes_databus_dir),
    .bus              (bus.dst),
    .map              (map.dst)
  );

endmodule

/* tb_snes_rom_ctrl.sv */
`timescale 1ns/1ns

module tb_snes_rom_ctrl import snes_rom_pkg::*; ();

  logic                   CLK2 = 1'b0;
  logic                   rst_n;
  logic [snes_addr_w-1:0] snes_addr_in;
  logic [byte_w-1:0]      snes_data_in;
  logic                   snes_rd_n;
  logic                   snes_wr_n;
  logic                   snes_cpu_clk;
  logic                   snes_cs_n;
  logic [byte_w-1:0]      snes_data_out;
  logic                   snes_data_oe;
  logic                   snes_databus_oe;
  logic                   snes_databus_dir;
  logic [rom_addr_w-1:0]  rom_addr;
  logic [rom_word_w-1:0]  rom_data_in;
  logic [rom_word_w-1:0]  rom_data_out;
  logic                   rom_data_oe;
  logic                   rom_we;
  logic                   rom_bhe;
  logic                   rom_ble;
  logic                   mcu_rrq;
  logic                   mcu_wrq;
  logic [snes_addr_w-1:0] mcu_addr;
  logic [byte_w-1:0]      mcu_dout;
  logic                   mcu_rdy;
  logic [byte_w-1:0]      mcu_din;
  logic                   mapper_hirom;
  logic [snes_addr_w-1:0] rom_mask;
  logic [snes_addr_w-1:0] saveram_mask;

  logic [15:0] mem     [65536];  // PSRAM as the DUT sees it
  logic [15:0] ref_mem [65536];  // Expected contents
  logic        load_mem;
  logic [15:0] lfsr;
  logic        mcu_done;
  int          errors;
  int          failed_tests;

  snes_rom_ctrl u_snes_rom_ctrl (.*);

  always #2 CLK2 = ~CLK2;

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);  // Galois, x^16+x^14+x^13+x^11+1
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // Byte address to model word, masks keep ROM below 64K and save RAM below 8K
  function automatic logic [15:0] widx(input logic [23:0] byte_addr);
    return {byte_addr[23], byte_addr[15:1]};
  endfunction

  function automatic logic [7:0] lane_byte(input logic [15:0] w, input logic a0);
    return a0 ? w[7:0] : w[15:8];  // Odd bytes on the low lane
  endfunction

  function automatic logic [23:0] map_ref(input logic hirom, input snes_addr_u a);
    if (hirom) begin
      if (a.hi.bank[6:5] == 2'b01 && a.hi.offset >= 16'h6000 && a.hi.offset <= 16'h7fff)
        return saveram_base + ({6'd0, a.hi.bank[4:0], a.hi.offset[12:0]} & saveram_mask);
      if (a.hi.bank[6] || a.hi.offset[15])
        return {2'd0, a.hi.bank[5:0], a.hi.offset} & rom_mask;
    end else begin
      if (a.lo.bank[6:4] == 3'b111 && !a.lo.a15)
        return saveram_base + ({5'd0, a.lo.bank[3:0], a.lo.page} & saveram_mask);
      if (a.lo.a15)
        return {2'd0, a.lo.bank[6:0], a.lo.page} & rom_mask;
    end
    return 24'h000000;  // Unmapped
  endfunction

  function automatic logic [23:0] rom_rand_addr(input logic hirom);
    logic [23:0] a;
    a = 24'(rand_bits(24));
    if (hirom) a[22] = 1'b1;  // Banks 40-7F / C0-FF
    else       a[15] = 1'b1;
    return a;
  endfunction

  function automatic logic [23:0] sav_rand_addr(input logic hirom);
    logic [23:0] a;
    a = 24'(rand_bits(24));
    if (hirom) begin
      a[22:21] = 2'b01;
      a[15:13] = 3'b011;  // 6000-7FFF
    end else begin
      a[22:20] = 3'b111;
      a[15]    = 1'b0;
    end
    return a;
  endfunction

  function automatic logic [23:0] mcu_rand_addr(input logic sav_only);
    logic [16:0] r;
    r = 17'(rand_bits(17));
    if (sav_only || r[16]) return saveram_base | {11'd0, r[12:0]};
    return {8'd0, r[15:0]};
  endfunction

  task automatic set_ref(input logic [23:0] a, input logic [7:0] b);
    if (a[0]) ref_mem[widx(a)][7:0]  = b;
    else      ref_mem[widx(a)][15:8] = b;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // PSRAM model
  ////////////////////////////////////////////////////////////////////////////
  assign rom_data_in = mem[widx({rom_addr, 1'b0})];

  always @(posedge CLK2) begin
    if (load_mem) begin
      for (int i = 0; i < 65536; i++) mem[i[15:0]] <= ref_mem[i[15:0]];
    end else if (!rom_we) begin
      if (!rom_ble) mem[widx({rom_addr, 1'b0})][7:0]  <= rom_data_out[7:0];
      if (!rom_bhe) mem[widx({rom_addr, 1'b0})][15:8] <= rom_data_out[15:8];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Bus tasks, all start and end on a falling edge
  ////////////////////////////////////////////////////////////////////////////
  task automatic mcu_access(input logic wr, input logic [23:0] a, input logic [7:0] wdat,
                            output logic [7:0] rdat);
    int n;
    mcu_addr = a;
    mcu_dout = wdat;
    mcu_wrq  = wr;
    mcu_rrq  = ~wr;
    @(negedge CLK2);
    mcu_rrq = 1'b0;
    mcu_wrq = 1'b0;
    for (n = 0; n < 400 && !mcu_rdy; n++) @(negedge CLK2);
    if (!mcu_rdy) begin
      $display("timeout: mcu_rdy did not come back after MCU access at %h", a);
      errors++;
    end
    rdat = mcu_din;
  endtask

  task automatic snes_read_check(input logic hirom, input logic [23:0] a, output logic oe);
    logic [23:0] m;
    logic [7:0]  exp;
    snes_addr_in = a;
    snes_cpu_clk = 1'b0;  // Cycle end, MCU slot opens here
    snes_rd_n    = 1'b1;
    repeat (8) @(negedge CLK2);
    snes_cpu_clk = 1'b1;
    snes_rd_n    = 1'b0;
    repeat (10) @(negedge CLK2);
    m   = map_ref(hirom, a);
    exp = lane_byte(ref_mem[widx(m)], m[0]);
    if (snes_data_out !== exp) begin
      $display("ERR snes_data_out got %h exp %h at %h", snes_data_out, exp, a);
      errors++;
    end
    if (snes_databus_dir !== 1'b1) begin
      $display("ERR snes_databus_dir got %h exp 1", snes_databus_dir);
      errors++;
    end
    if (snes_data_oe !== 1'b1) begin
      $display("ERR snes_data_oe got %h exp 1", snes_data_oe);
      errors++;
    end
    oe        = snes_databus_oe;
    snes_rd_n = 1'b1;
  endtask

  task automatic snes_write(input logic [23:0] a, input logic [7:0] d);
    snes_addr_in = a;
    snes_data_in = d;
    snes_cpu_clk = 1'b0;
    snes_wr_n    = 1'b1;
    repeat (8) @(negedge CLK2);
    snes_cpu_clk = 1'b1;
    snes_wr_n    = 1'b0;
    repeat (8) @(negedge CLK2);
    // Cartridge region hit, so the PSRAM data pins are driven
    if (rom_data_oe !== 1'b1) begin
      $display("ERR rom_data_oe got %h exp 1 at %h", rom_data_oe, a);
      errors++;
    end
    snes_wr_n = 1'b1;  // Address held until the clock falls
    repeat (8) @(negedge CLK2);
    snes_cpu_clk = 1'b0;
    repeat (8) @(negedge CLK2);
  endtask

  task automatic end_test(input string name, input int err_start);
    if (errors == err_start) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errors - err_start);
      failed_tests++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////////////
  initial begin
    int          k;
    int          n;
    int          mode;
    int          err_start;
    logic [23:0] m_addr;
    logic [7:0]  m_wdat;
    logic [7:0]  m_rdat;
    logic [7:0]  m_exp;
    logic [23:0] s_addr;
    logic [23:0] s_map;
    logic [7:0]  s_data;
    logic [7:0]  s_exp;
    logic        s_oe;

    lfsr         = 16'd56302;
    errors       = 0;
    failed_tests = 0;
    rst_n        = 1'b0;
    load_mem     = 1'b1;
    snes_addr_in = '0;
    snes_data_in = '0;
    snes_rd_n    = 1'b1;
    snes_wr_n    = 1'b1;
    snes_cpu_clk = 1'b0;  // Console stopped
    snes_cs_n    = 1'b1;
    mcu_rrq      = 1'b0;
    mcu_wrq      = 1'b0;
    mcu_addr     = '0;
    mcu_dout     = '0;
    mapper_hirom = 1'b0;
    rom_mask     = 24'h00ffff;
    saveram_mask = 24'h001fff;
    mcu_done     = 1'b0;
    for (int i = 0; i < 65536; i++) ref_mem[i[15:0]] = 16'(rand_bits(16));
    repeat (3) @(negedge CLK2);
    rst_n    = 1'b1;
    load_mem = 1'b0;
    @(negedge CLK2);

    err_start = errors;
    if (mcu_rdy !== 1'b1) begin
      $display("ERR mcu_rdy got %h exp 1", mcu_rdy);
      errors++;
    end
    if (rom_we !== 1'b1) begin
      $display("ERR rom_we got %h exp 1", rom_we);
      errors++;
    end
    if (snes_databus_dir !== 1'b0) begin
      $display("ERR snes_databus_dir got %h exp 0", snes_databus_dir);
      errors++;
    end
    end_test("reset state", err_start);

    err_start = errors;
    for (k = 0; k < 8; k++) begin
      m_addr = mcu_rand_addr(1'b0);
      m_wdat = 8'(rand_bits(8));
      mcu_access(1'b1, m_addr, m_wdat, m_rdat);
      set_ref(m_addr, m_wdat);
      mcu_access(1'b0, m_addr, 8'h00, m_rdat);
      if (m_rdat !== m_wdat) begin
        $display("ERR mcu_din got %h exp %h at %h", m_rdat, m_wdat, m_addr);
        errors++;
      end
    end
    end_test("mcu access, console dead", err_start);

    err_start = errors;
    for (mode = 0; mode < 2; mode++) begin
      mapper_hirom = mode[0];
      for (k = 0; k < 8; k++) snes_read_check(mode[0], rom_rand_addr(mode[0]), s_oe);
    end
    end_test("snes rom reads", err_start);

    err_start = errors;
    for (mode = 0; mode < 2; mode++) begin
      mapper_hirom = mode[0];
      for (k = 0; k < 4; k++) begin
        s_addr = sav_rand_addr(mode[0]);
        s_data = 8'(rand_bits(8));
        snes_write(s_addr, s_data);
        s_map = map_ref(mode[0], s_addr);
        set_ref(s_map, s_data);
        s_exp = lane_byte(mem[widx(s_map)], s_map[0]);
        if (s_exp !== s_data) begin
          $display("ERR save ram byte at %h got %h exp %h", s_map, s_exp, s_data);
          errors++;
        end
        // ROM is read only for the console
        s_addr = rom_rand_addr(mode[0]);
        snes_write(s_addr, 8'(rand_bits(8)));
        s_map = map_ref(mode[0], s_addr);
        s_exp = lane_byte(ref_mem[widx(s_map)], s_map[0]);
        if (lane_byte(mem[widx(s_map)], s_map[0]) !== s_exp) begin
          $display("ERR rom byte at %h got %h exp %h", s_map,
                   lane_byte(mem[widx(s_map)], s_map[0]), s_exp);
          errors++;
        end
      end
    end
    end_test("snes writes", err_start);

    err_start    = errors;
    mapper_hirom = 1'b0;
    fork
      begin
        for (n = 0; n < 200 && !mcu_done; n++) snes_read_check(1'b0, rom_rand_addr(1'b0), s_oe);
      end
      begin
        for (k = 0; k < 6; k++) begin
          m_addr = mcu_rand_addr(1'b1);  // Save RAM only, SNES reads stay on ROM
          m_wdat = 8'(rand_bits(8));
          mcu_access(1'b1, m_addr, m_wdat, m_rdat);
          set_ref(m_addr, m_wdat);
          mcu_access(1'b0, m_addr, 8'h00, m_rdat);
          if (m_rdat !== m_wdat) begin
            $display("ERR mcu_din got %h exp %h at %h", m_rdat, m_wdat, m_addr);
            errors++;
          end
          m_addr = mcu_rand_addr(1'b0);
          mcu_access(1'b0, m_addr, 8'h00, m_rdat);
          m_exp = lane_byte(ref_mem[widx(m_addr)], m_addr[0]);
          if (m_rdat !== m_exp) begin
            $display("ERR mcu_din got %h exp %h at %h", m_rdat, m_exp, m_addr);
            errors++;
          end
        end
        mcu_done = 1'b1;
      end
    join
    end_test("mcu access, console running", err_start);

    err_start = errors;
    snes_cs_n = 1'b0;
    snes_read_check(1'b0, rom_rand_addr(1'b0), s_oe);
    if (s_oe !== 1'b0) begin
      $display("ERR snes_databus_oe got %h exp 0 during read", s_oe);
      errors++;
    end
    repeat (8) @(negedge CLK2);
    if (snes_databus_oe !== 1'b1) begin
      $display("ERR snes_databus_oe got %h exp 1 on idle bus", snes_databus_oe);
      errors++;
    end
    end_test("bus enable", err_start);

    $display("%0d of 6 tests failed, %0d errors in total", failed_tests, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* snes_rom_ctrl.f */
snes_rom_pkg.sv
snes_bus_if.sv
addr_map_if.sv
snes_bus_sync.sv
snes_addr_map.sv
mcu_rom_arbiter.sv
rom_bus_drive.sv
snes_rom_ctrl.sv
tb_snes_rom_ctrl.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --top-module tb_snes_rom_ctrl -f snes_rom_ctrl.f -o tb_snes_rom_ctrl \
  && ./obj_dir/tb_snes_rom_ctrl > sim.log 2>&1 \
  || echo "build or simulation failed" >> sim.log
cat sim.log
grep -q "ALL TESTS PASSED" sim.log && echo "RESULT: PASS" || { echo "RESULT: FAIL"; exit 1; }
